// File: include/rob_macros.svh
// sizes of the reorder buffer, its side channels and the retire register block; include where needed
`ifndef ROB_MACROS_SVH
`define ROB_MACROS_SVH

// log2 of the number of buffer slots
`define ROB_IDX_W 7

// slot index plus one wrap polarity bit
`define ROB_ID_W (`ROB_IDX_W + 1)

`define ROB_DEPTH (1 << `ROB_IDX_W)

// load/store queue index and predictor tag
`define LSQ_ID_W 5
`define BPTAG_W 16

// word address of the wishbone register block
`define REG_ADR_W 2

`endif

// File: logic/rob_types_pkg.sv
// types shared by the reorder buffer and its neighbours: identifiers, retire kinds, causes
`include "rob_macros.svh"

package rob_types_pkg;

  // slot index, and full identifier with wrap polarity in the msb
  typedef logic [`ROB_IDX_W-1:0] rob_idx_t;
  typedef logic [`ROB_ID_W-1:0]  rob_id_t;

  // what the retiring instruction does besides its result
  typedef enum logic [2:0] {
    RETOP_ALU    = 3'd0,
    RETOP_LOAD   = 3'd1,
    RETOP_STORE  = 3'd2,
    RETOP_BRANCH = 3'd3,
    RETOP_JUMP   = 3'd4
  } retop_e;

  // set at decode when the branch condition is the inverse of result bit 0
  typedef logic branch_inv_t;

  // riscv exception codes the core can raise
  typedef enum logic [4:0] {
    ECAUSE_FETCH_MISALIGNED = 5'd0,
    ECAUSE_FETCH_FAULT      = 5'd1,
    ECAUSE_ILLEGAL          = 5'd2,
    ECAUSE_BREAKPOINT       = 5'd3,
    ECAUSE_LOAD_MISALIGNED  = 5'd4,
    ECAUSE_LOAD_FAULT       = 5'd5,
    ECAUSE_STORE_MISALIGNED = 5'd6,
    ECAUSE_STORE_FAULT      = 5'd7
  } ecause_e;

endpackage

// File: logic/rob_regs_pkg.sv
// address map and data type of the wishbone retire register block
`include "rob_macros.svh"

package rob_regs_pkg;

  typedef logic [31:0] reg_data_t;

  // epc and cause are read only; a write to retcnt clears the counter
  typedef enum logic [`REG_ADR_W-1:0] {
    REG_TVEC   = 2'd0,
    REG_EPC    = 2'd1,
    REG_CAUSE  = 2'd2,
    REG_RETCNT = 2'd3
  } reg_addr_e;

endpackage

// File: logic/retire_if.sv
// retirement events from the reorder buffer to the register block, one beat per retired entry
`timescale 1ns/1ps

interface retire_if;

  // one cycle per retired entry, exceptions included
  logic                   ret;
  // retiring entry carries an error
  logic                   exc;
  logic [31:0]            epc;
  rob_types_pkg::ecause_e ecause;

  modport rob_side (
    output ret,
    output exc,
    output epc,
    output ecause
  );

  modport regs_side (
    input ret,
    input exc,
    input epc,
    input ecause
  );

endinterface

// File: logic/reorder_buffer.sv
// reorder buffer: allocates in order, takes writebacks in any order, retires one entry per cycle
`timescale 1ns/1ps
`include "rob_macros.svh"

module reorder_buffer (
  input  logic                       clk,
  input  logic                       rst,
  // decode
  input  logic                       valid,
  input  logic                       error,
  input  rob_types_pkg::ecause_e     ecause,
  input  rob_types_pkg::retop_e      retop,
  input  rob_types_pkg::branch_inv_t branch_inv,
  input  logic [31:0]                pc,
  input  logic [4:0]                 rd,
  input  logic                       rd_en,
  input  logic [`BPTAG_W-1:0]        bptag,
  input  logic                       bptaken,
  input  logic [31:0]                target,
  output logic                       full,
  output rob_types_pkg::rob_id_t     robid,
  // store tagging from the lsq
  input  logic                       lsq_write,
  input  rob_types_pkg::rob_id_t     lsq_robid,
  input  logic [`LSQ_ID_W-1:0]       lsq_id,
  // execution writeback
  input  logic                       ex_valid,
  input  logic                       ex_error,
  input  rob_types_pkg::ecause_e     ex_ecause,
  input  rob_types_pkg::rob_id_t     ex_robid,
  input  logic [31:0]                ex_result,
  input  logic [31:0]                tvec,
  // retirement
  output logic                       ret_valid,
  output logic [4:0]                 ret_rd,
  output logic [31:0]                ret_result,
  output logic                       ret_branch,
  output logic [`BPTAG_W-1:0]        ret_bptag,
  output logic                       ret_taken,
  output logic                       ret_store,
  output logic [`LSQ_ID_W-1:0]       ret_lsqid,
  output logic                       flush,
  output logic [31:0]                flush_pc,
  retire_if.rob_side                 ev
);

  // per-slot entry store
  logic [`ROB_DEPTH-1:0]        buf_executed;
  logic [`ROB_DEPTH-1:0]        buf_error;
  logic [`ROB_DEPTH-1:0]        buf_rd_en;
  logic [`ROB_DEPTH-1:0]        buf_inv;
  logic [`ROB_DEPTH-1:0]        buf_bptaken;
  rob_types_pkg::retop_e        buf_retop [`ROB_DEPTH];
  rob_types_pkg::ecause_e       buf_cause [`ROB_DEPTH];
  logic [31:0]                  buf_pc [`ROB_DEPTH];
  logic [4:0]                   buf_rd [`ROB_DEPTH];
  logic [31:0]                  buf_result [`ROB_DEPTH];
  logic [31:0]                  buf_target [`ROB_DEPTH];
  logic [`BPTAG_W-1:0]          buf_bptag [`ROB_DEPTH];
  logic [`LSQ_ID_W-1:0]         buf_lsqid [`ROB_DEPTH];

  // retire at head, allocate at tail
  rob_types_pkg::rob_id_t       head;
  rob_types_pkg::rob_id_t       tail;
  rob_types_pkg::rob_id_t       head_next;
  rob_types_pkg::rob_id_t       rd_ptr;
  rob_types_pkg::rob_idx_t      rd_slot;
  rob_types_pkg::rob_idx_t      tail_slot;

  // registered head entry, valid for exactly its retire cycle
  logic                         q_valid;
  logic                         q_error;
  logic                         q_rd_en;
  logic                         q_inv;
  logic                         q_bptaken;
  rob_types_pkg::retop_e        q_retop;
  rob_types_pkg::ecause_e       q_cause;
  logic [31:0]                  q_pc;
  logic [4:0]                   q_rd;
  logic [31:0]                  q_result;
  logic [31:0]                  q_target;
  logic [`BPTAG_W-1:0]          q_bptag;
  logic [`LSQ_ID_W-1:0]         q_lsqid;

  logic                         alloc;
  logic                         taken;
  logic                         mispredict;

  assign head_next = head + rob_types_pkg::rob_id_t'(1);
  // look one past head while an entry retires so neighbours go back to back
  assign rd_ptr    = q_valid ? head_next : head;
  assign rd_slot   = rd_ptr[`ROB_IDX_W-1:0];
  assign tail_slot = tail[`ROB_IDX_W-1:0];

  // same slot, opposite lap
  assign full  = (head[`ROB_IDX_W-1:0] == tail_slot) && (head[`ROB_IDX_W] != tail[`ROB_IDX_W]);
  assign robid = tail;
  assign alloc = valid && !full;

  assign taken      = q_result[0] ^ q_inv;
  assign mispredict = (q_retop == rob_types_pkg::RETOP_BRANCH) && (taken != q_bptaken);

  assign ret_valid  = q_valid && !q_error && q_rd_en;
  assign ret_rd     = q_rd;
  assign ret_result = q_result;
  assign ret_branch = q_valid && (q_retop == rob_types_pkg::RETOP_BRANCH);
  assign ret_bptag  = q_bptag;
  assign ret_taken  = taken;
  assign ret_store  = q_valid && !q_error && (q_retop == rob_types_pkg::RETOP_STORE);
  assign ret_lsqid  = q_lsqid;

  assign flush    = q_valid && (q_error || (q_retop == rob_types_pkg::RETOP_JUMP) || mispredict);
  assign flush_pc = q_error ? tvec : q_target;

  assign ev.ret    = q_valid;
  assign ev.exc    = q_valid && q_error;
  assign ev.epc    = q_pc;
  assign ev.ecause = q_cause;

  // a flush empties the buffer; numbering continues after the flushing entry
  always_ff @(posedge clk) begin
    if (rst) begin
      head <= '0;
      tail <= '0;
    end else begin
      if (q_valid) begin
        head <= head_next;
      end
      if (flush) begin
        tail <= head_next;
      end else if (alloc) begin
        tail <= tail + rob_types_pkg::rob_id_t'(1);
      end
    end
  end

  // compare against tail so stale executed bits never retire
  always_ff @(posedge clk) begin
    if (rst || flush) begin
      q_valid <= 1'b0;
    end else begin
      q_valid <= buf_executed[rd_slot] && (rd_ptr != tail);
    end
  end

  always_ff @(posedge clk) begin
    q_error   <= buf_error[rd_slot];
    q_rd_en   <= buf_rd_en[rd_slot];
    q_inv     <= buf_inv[rd_slot];
    q_bptaken <= buf_bptaken[rd_slot];
    q_retop   <= buf_retop[rd_slot];
    q_cause   <= buf_cause[rd_slot];
    q_pc      <= buf_pc[rd_slot];
    q_rd      <= buf_rd[rd_slot];
    q_result  <= buf_result[rd_slot];
    q_target  <= buf_target[rd_slot];
    q_bptag   <= buf_bptag[rd_slot];
    q_lsqid   <= buf_lsqid[rd_slot];
  end

  // writeback comes last so it wins over allocation
  always_ff @(posedge clk) begin
    if (alloc) begin
      buf_executed[tail_slot] <= 1'b0;
      buf_error[tail_slot]    <= error;
      buf_cause[tail_slot]    <= ecause;
      buf_retop[tail_slot]    <= retop;
      buf_inv[tail_slot]      <= branch_inv;
      buf_pc[tail_slot]       <= pc;
      buf_rd[tail_slot]       <= rd;
      buf_rd_en[tail_slot]    <= rd_en;
      buf_bptag[tail_slot]    <= bptag;
      buf_bptaken[tail_slot]  <= bptaken;
      buf_target[tail_slot]   <= target;
    end
    if (lsq_write) begin
      buf_lsqid[lsq_robid[`ROB_IDX_W-1:0]] <= lsq_id;
    end
    if (ex_valid) begin
      buf_executed[ex_robid[`ROB_IDX_W-1:0]] <= 1'b1;
      buf_error[ex_robid[`ROB_IDX_W-1:0]]    <= ex_error;
      buf_cause[ex_robid[`ROB_IDX_W-1:0]]    <= ex_ecause;
      buf_result[ex_robid[`ROB_IDX_W-1:0]]   <= ex_result;
    end
  end

endmodule

// File: logic/retire_regs.sv
// wishbone-classic register block: trap vector, exception pc and cause, retired instruction count
`timescale 1ns/1ps

module retire_regs (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     wb_cyc,
  input  logic                     wb_stb,
  input  logic                     wb_we,
  input  rob_regs_pkg::reg_addr_e  wb_adr,
  input  rob_regs_pkg::reg_data_t  wb_dat_w,
  output rob_regs_pkg::reg_data_t  wb_dat_r,
  output logic                     wb_ack,
  output rob_regs_pkg::reg_data_t  tvec,
  retire_if.regs_side              ev
);

  // high from the first cycle of a strobe until it drops
  logic                     req_seen;
  logic                     req;
  logic                     wr;
  rob_regs_pkg::reg_data_t  epc;
  rob_types_pkg::ecause_e   cause;
  rob_regs_pkg::reg_data_t  ret_count;
  rob_regs_pkg::reg_data_t  rd_data;

  assign req = wb_cyc && wb_stb && !req_seen;
  assign wr  = req && wb_we;

  // single ack per strobe
  always_ff @(posedge clk) begin
    if (rst) begin
      req_seen <= 1'b0;
      wb_ack   <= 1'b0;
    end else begin
      req_seen <= wb_cyc && wb_stb;
      wb_ack   <= req;
    end
  end

  always_comb begin
    case (wb_adr)
      rob_regs_pkg::REG_TVEC:  rd_data = tvec;
      rob_regs_pkg::REG_EPC:   rd_data = epc;
      rob_regs_pkg::REG_CAUSE: rd_data = {{27{1'b0}}, cause};
      default:                 rd_data = ret_count;
    endcase
  end

  always_ff @(posedge clk) begin
    if (req) begin
      wb_dat_r <= rd_data;
    end
  end

  // trap vector is word aligned
  always_ff @(posedge clk) begin
    if (rst) begin
      tvec <= '0;
    end else if (wr && wb_adr == rob_regs_pkg::REG_TVEC) begin
      tvec <= {wb_dat_w[31:2], 2'b00};
    end
  end

  // captured at the end of the exception's retire cycle
  always_ff @(posedge clk) begin
    if (ev.exc) begin
      epc   <= ev.epc;
      cause <= ev.ecause;
    end
  end

  // exceptions count as retired too; software clear wins
  always_ff @(posedge clk) begin
    if (rst) begin
      ret_count <= '0;
    end else if (wr && wb_adr == rob_regs_pkg::REG_RETCNT) begin
      ret_count <= '0;
    end else if (ev.ret) begin
      ret_count <= ret_count + 32'd1;
    end
  end

endmodule

// File: logic/retire_top.sv
// retirement stage top level: reorder buffer plus its wishbone register block, plain ports only
`timescale 1ns/1ps
`include "rob_macros.svh"

module retire_top (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       valid,
  input  logic                       error,
  input  rob_types_pkg::ecause_e     ecause,
  input  rob_types_pkg::retop_e      retop,
  input  rob_types_pkg::branch_inv_t branch_inv,
  input  logic [31:0]                pc,
  input  logic [4:0]                 rd,
  input  logic                       rd_en,
  input  logic [`BPTAG_W-1:0]        bptag,
  input  logic                       bptaken,
  input  logic [31:0]                target,
  output logic                       full,
  output rob_types_pkg::rob_id_t     robid,
  input  logic                       lsq_write,
  input  rob_types_pkg::rob_id_t     lsq_robid,
  input  logic [`LSQ_ID_W-1:0]       lsq_id,
  input  logic                       ex_valid,
  input  logic                       ex_error,
  input  rob_types_pkg::ecause_e     ex_ecause,
  input  rob_types_pkg::rob_id_t     ex_robid,
  input  logic [31:0]                ex_result,
  output logic                       ret_valid,
  output logic [4:0]                 ret_rd,
  output logic [31:0]                ret_result,
  output logic                       ret_branch,
  output logic [`BPTAG_W-1:0]        ret_bptag,
  output logic                       ret_taken,
  output logic                       ret_store,
  output logic [`LSQ_ID_W-1:0]       ret_lsqid,
  output logic                       flush,
  output logic [31:0]                flush_pc,
  input  logic                       wb_cyc,
  input  logic                       wb_stb,
  input  logic                       wb_we,
  input  rob_regs_pkg::reg_addr_e    wb_adr,
  input  rob_regs_pkg::reg_data_t    wb_dat_w,
  output rob_regs_pkg::reg_data_t    wb_dat_r,
  output logic                       wb_ack
);

  rob_regs_pkg::reg_data_t tvec;

  retire_if ev ();

  reorder_buffer reorder_buffer_i (
    .clk(clk), .rst(rst),
    .valid(valid), .error(error), .ecause(ecause), .retop(retop),
    .branch_inv(branch_inv), .pc(pc), .rd(rd), .rd_en(rd_en),
    .bptag(bptag), .bptaken(bptaken), .target(target),
    .full(full), .robid(robid),
    .lsq_write(lsq_write), .lsq_robid(lsq_robid), .lsq_id(lsq_id),
    .ex_valid(ex_valid), .ex_error(ex_error), .ex_ecause(ex_ecause),
    .ex_robid(ex_robid), .ex_result(ex_result),
    .tvec(tvec),
    .ret_valid(ret_valid), .ret_rd(ret_rd), .ret_result(ret_result),
    .ret_branch(ret_branch), .ret_bptag(ret_bptag), .ret_taken(ret_taken),
    .ret_store(ret_store), .ret_lsqid(ret_lsqid),
    .flush(flush), .flush_pc(flush_pc),
    .ev(ev.rob_side)
  );

  retire_regs retire_regs_i (
    .clk(clk), .rst(rst),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
    .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
    .tvec(tvec),
    .ev(ev.regs_side)
  );

endmodule

// File: testbench/retire_tb.sv
// simulation top for retire_top that applies a table of decode rows and checks every retirement
`timescale 1ns/1ps
`include "rob_macros.svh"

module retire_tb;

  typedef struct packed {
    rob_types_pkg::retop_e  op;
    logic [4:0]             rd;
    logic                   rd_en;
    logic                   inv;
    logic                   bptaken;
    logic [31:0]            target;
    logic [31:0]            result;
    logic                   err;
    rob_types_pkg::ecause_e cause;
    logic [`LSQ_ID_W-1:0]   lsq;
    logic [2:0]             gap;
    logic                   exp_taken;
    logic                   exp_flush;
  } row_t;

  typedef struct packed {
    logic                 wr;
    logic [4:0]           rd;
    logic [31:0]          result;
    logic                 branch;
    logic [`BPTAG_W-1:0]  bptag;
    logic                 taken;
    logic                 store;
    logic [`LSQ_ID_W-1:0] lsqid;
    logic                 flush;
    logic [31:0]          flush_pc;
  } exp_t;

  logic clk, rst, valid, error, rd_en, bptaken, full;
  rob_types_pkg::ecause_e ecause, ex_ecause;
  rob_types_pkg::retop_e retop;
  rob_types_pkg::branch_inv_t branch_inv;
  logic [31:0] pc, target, ex_result, ret_result, flush_pc;
  logic [4:0] rd, ret_rd;
  logic [`BPTAG_W-1:0] bptag, ret_bptag;
  rob_types_pkg::rob_id_t robid, lsq_robid, ex_robid;
  logic lsq_write, ex_valid, ex_error, ret_valid, ret_branch, ret_taken, ret_store, flush;
  logic [`LSQ_ID_W-1:0] lsq_id, ret_lsqid;
  logic wb_cyc, wb_stb, wb_we, wb_ack;
  rob_regs_pkg::reg_addr_e wb_adr;
  rob_regs_pkg::reg_data_t wb_dat_w, wb_dat_r;

  // op, rd, rd_en, inv, bptaken, target, result
  // err, cause, lsq, gap, exp_taken, exp_flush
  row_t rows [0:15] = '{
    // in-order retirement, store and predicted branches
    '{rob_types_pkg::RETOP_ALU, 5'd1, 1'b1, 1'b0, 1'b0, 32'h0, 32'h11,
      1'b0, rob_types_pkg::ECAUSE_ILLEGAL, 5'd0, 3'd2, 1'b0, 1'b0},
    '{rob_types_pkg::RETOP_LOAD, 5'd2, 1'b1, 1'b0, 1'b0, 32'h0, 32'h22,
      1'b0, rob_types_pkg::ECAUSE_ILLEGAL, 5'd0, 3'd0, 1'b0, 1'b0},
    '{rob_types_pkg::RETOP_ALU, 5'd3, 1'b0, 1'b0, 1'b0, 32'h0, 32'h33,
      1'b0, rob_types_pkg::ECAUSE_ILLEGAL, 5'd0, 3'd1, 1'b0, 1'b0},
    '{rob_types_pkg::RETOP_STORE, 5'd0, 1'b0, 1'b0, 1'b0, 32'h0, 32'h0,
      1'b0, rob_types_pkg::ECAUSE_ILLEGAL, 5'd5, 3'd0, 1'b0, 1'b0},
    '{rob_types_pkg::RETOP_BRANCH, 5'd0, 1'b0, 1'b0, 1'b1, 32'h2000, 32'h1,
      1'b0, rob_types_pkg::ECAUSE_ILLEGAL, 5'd0, 3'd3, 1'b1, 1'b0},
    '{rob_types_pkg::RETOP_BRANCH, 5'd0, 1'b0, 1'b1, 1'b0, 32'h3000, 32'h1,
      1'b0, rob_types_pkg::ECAUSE_ILLEGAL, 5'd0, 3'd0, 1'b0, 1'b0},
    '{rob_types_pkg::RETOP_ALU, 5'd7, 1'b1, 1'b0, 1'b0, 32'h0, 32'h77,
      1'b0, rob_types_pkg::ECAUSE_ILLEGAL, 5'd0, 3'd1, 1'b0, 1'b0},
    // mispredicted branch with two younger entries
    '{rob_types_pkg::RETOP_ALU, 5'd8, 1'b1, 1'b0, 1'b0, 32'h0, 32'h88,
      1'b0, rob_types_pkg::ECAUSE_ILLEGAL, 5'd0, 3'd0, 1'b0, 1'b0},
    '{rob_types_pkg::RETOP_BRANCH, 5'd0, 1'b0, 1'b0, 1'b1, 32'h400, 32'h0,
      1'b0, rob_types_pkg::ECAUSE_ILLEGAL, 5'd0, 3'd1, 1'b0, 1'b1},
    '{rob_types_pkg::RETOP_ALU, 5'd9, 1'b1, 1'b0, 1'b0, 32'h0, 32'h99,
      1'b0, rob_types_pkg::ECAUSE_ILLEGAL, 5'd0, 3'd0, 1'b0, 1'b0},
    '{rob_types_pkg::RETOP_ALU, 5'd10, 1'b1, 1'b0, 1'b0, 32'h0, 32'haa,
      1'b0, rob_types_pkg::ECAUSE_ILLEGAL, 5'd0, 3'd2, 1'b0, 1'b0},
    // jump with link write
    '{rob_types_pkg::RETOP_JUMP, 5'd1, 1'b1, 1'b0, 1'b0, 32'h800, 32'h1030,
      1'b0, rob_types_pkg::ECAUSE_ILLEGAL, 5'd0, 3'd0, 1'b0, 1'b1},
    '{rob_types_pkg::RETOP_ALU, 5'd2, 1'b1, 1'b0, 1'b0, 32'h0, 32'hbb,
      1'b0, rob_types_pkg::ECAUSE_ILLEGAL, 5'd0, 3'd1, 1'b0, 1'b0},
    // load fault traps to the programmed vector
    '{rob_types_pkg::RETOP_ALU, 5'd4, 1'b1, 1'b0, 1'b0, 32'h0, 32'h44,
      1'b0, rob_types_pkg::ECAUSE_ILLEGAL, 5'd0, 3'd1, 1'b0, 1'b0},
    '{rob_types_pkg::RETOP_LOAD, 5'd5, 1'b1, 1'b0, 1'b0, 32'h0, 32'hdead,
      1'b1, rob_types_pkg::ECAUSE_LOAD_FAULT, 5'd0, 3'd0, 1'b0, 1'b1},
    '{rob_types_pkg::RETOP_ALU, 5'd6, 1'b1, 1'b0, 1'b0, 32'h0, 32'h66,
      1'b0, rob_types_pkg::ECAUSE_ILLEGAL, 5'd0, 3'd0, 1'b0, 1'b0}
  };

  exp_t exp_q [$];
  int retired;
  string test_name;
  logic [31:0] tvec_val;

  retire_top retire_top_i (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic stop_failed();
    $display("TB FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic mismatch(input string what, input logic [31:0] exp_v, input logic [31:0] act_v);
    $display("** Error [%s] %s: expected %h, actual %h", test_name, what, exp_v, act_v);
    stop_failed();
  endtask

  task automatic give_up(input string msg);
    $display("[%s] %s", test_name, msg);
    stop_failed();
  endtask

  task automatic check_ret(input logic exp_wr, input logic [4:0] exp_rd,
                           input logic [31:0] exp_res);
    if (ret_valid !== exp_wr) mismatch("ret_valid", 32'(exp_wr), 32'(ret_valid));
    if (exp_wr && ret_rd !== exp_rd) mismatch("ret_rd", 32'(exp_rd), 32'(ret_rd));
    if (exp_wr && ret_result !== exp_res) mismatch("ret_result", exp_res, ret_result);
  endtask

  task automatic check_branch(input logic exp_br, input logic [`BPTAG_W-1:0] exp_tag,
                              input logic exp_taken);
    if (ret_branch !== exp_br) mismatch("ret_branch", 32'(exp_br), 32'(ret_branch));
    if (exp_br && ret_bptag !== exp_tag) mismatch("ret_bptag", 32'(exp_tag), 32'(ret_bptag));
    if (exp_br && ret_taken !== exp_taken) mismatch("ret_taken", 32'(exp_taken), 32'(ret_taken));
  endtask

  task automatic check_store(input logic exp_st, input logic [`LSQ_ID_W-1:0] exp_id);
    if (ret_store !== exp_st) mismatch("ret_store", 32'(exp_st), 32'(ret_store));
    if (exp_st && ret_lsqid !== exp_id) mismatch("ret_lsqid", 32'(exp_id), 32'(ret_lsqid));
  endtask

  task automatic check_flush(input logic exp_fl, input logic [31:0] exp_pc);
    if (flush !== exp_fl) mismatch("flush", 32'(exp_fl), 32'(flush));
    if (exp_fl && flush_pc !== exp_pc) mismatch("flush_pc", exp_pc, flush_pc);
  endtask

  task automatic check_id(input rob_types_pkg::rob_id_t exp_id,
                          input rob_types_pkg::rob_id_t act_id);
    if (act_id !== exp_id) mismatch("robid", 32'(exp_id), 32'(act_id));
  endtask

  task automatic check_full(input logic exp_full);
    if (full !== exp_full) mismatch("full", 32'(exp_full), 32'(full));
  endtask

  function automatic logic silent(input exp_t e);
    return !e.wr && !e.branch && !e.store && !e.flush;
  endfunction

  // match any visible retirement against the oldest pending entry
  task automatic observe();
    exp_t e;
    if (ret_valid || ret_branch || ret_store || flush) begin
      while (exp_q.size() > 0 && silent(exp_q[0])) begin
        void'(exp_q.pop_front());
        retired++;
      end
      if (exp_q.size() == 0) give_up("an entry retired that should not have");
      e = exp_q.pop_front();
      retired++;
      check_ret(e.wr, e.rd, e.result);
      check_branch(e.branch, e.bptag, e.taken);
      check_store(e.store, e.lsqid);
      check_flush(e.flush, e.flush_pc);
    end
  endtask

  task automatic tick();
    @(posedge clk);
    #2;
    observe();
  endtask

  task automatic wb_access(input logic we, input rob_regs_pkg::reg_addr_e adr,
                           input rob_regs_pkg::reg_data_t wdata,
                           output rob_regs_pkg::reg_data_t rdata);
    int waited;
    waited = 0;
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we = we;
    wb_adr = adr;
    wb_dat_w = wdata;
    tick();
    while (wb_ack !== 1'b1) begin
      if (waited == 20) give_up("wishbone ack never came");
      tick();
      waited++;
    end
    rdata = wb_dat_r;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    tick();
  endtask

  task automatic check_reg(input rob_regs_pkg::reg_addr_e adr,
                           input rob_regs_pkg::reg_data_t exp_d);
    rob_regs_pkg::reg_data_t d;
    wb_access(1'b0, adr, '0, d);
    if (d !== exp_d) mismatch($sformatf("register %s", adr.name()), exp_d, d);
  endtask

  function automatic logic [31:0] pc_of(input int i);
    return 32'h0000_1000 + 32'(i) * 32'd4;
  endfunction

  // decode holds its inputs while full is high
  task automatic decode_row(input row_t r, input int i, output rob_types_pkg::rob_id_t id);
    int waited;
    waited = 0;
    valid = 1'b1;
    error = 1'b0;
    ecause = r.cause;
    retop = r.op;
    branch_inv = r.inv;
    pc = pc_of(i);
    rd = r.rd;
    rd_en = r.rd_en;
    bptag = 16'hb000 + 16'(i);
    bptaken = r.bptaken;
    target = r.target;
    while (full) begin
      if (waited == 200) give_up("decode was held off by full for too long");
      tick();
      waited++;
    end
    id = robid;
    tick();
    valid = 1'b0;
  endtask

  task automatic write_back(input row_t r, input rob_types_pkg::rob_id_t id);
    repeat (r.gap) tick();
    ex_valid = 1'b1;
    ex_error = r.err;
    ex_ecause = r.cause;
    ex_robid = id;
    ex_result = r.result;
    if (r.op == rob_types_pkg::RETOP_STORE) begin
      lsq_write = 1'b1;
      lsq_robid = id;
      lsq_id = r.lsq;
    end
    tick();
    ex_valid = 1'b0;
    lsq_write = 1'b0;
  endtask

  task automatic run_group(input string name, input int first, input int n);
    rob_types_pkg::rob_id_t ids [0:15];
    int order [0:15];
    int k;
    int tmp;
    int waited;
    int flush_row;
    exp_t e;
    row_t r;
    test_name = name;
    flush_row = -1;
    for (int i = 0; i < n; i++) begin
      r = rows[first + i];
      if (flush_row < 0) begin
        e.wr = r.rd_en && !r.err;
        e.rd = r.rd;
        e.result = r.result;
        e.branch = (r.op == rob_types_pkg::RETOP_BRANCH);
        e.bptag = 16'hb000 + 16'(first + i);
        e.taken = r.exp_taken;
        e.store = (r.op == rob_types_pkg::RETOP_STORE) && !r.err;
        e.lsqid = r.lsq;
        e.flush = r.exp_flush;
        e.flush_pc = r.err ? tvec_val : r.target;
        exp_q.push_back(e);
        if (r.exp_flush) flush_row = i;
      end
    end
    for (int i = 0; i < n; i++) decode_row(rows[first + i], first + i, ids[i]);
    // scrambled writeback order
    for (int i = 0; i < n; i++) order[i] = i;
    for (int i = n - 1; i > 0; i--) begin
      k = int'($urandom % 32'(i + 1));
      tmp = order[i];
      order[i] = order[k];
      order[k] = tmp;
    end
    for (int i = 0; i < n; i++) write_back(rows[first + order[i]], ids[order[i]]);
    waited = 0;
    while (exp_q.size() > 0) begin
      if (waited == 300) give_up("expected retirements did not all arrive");
      tick();
      waited++;
    end
    repeat (4) tick();
    if (flush_row >= 0) check_id(ids[flush_row] + 1'b1, robid);
  endtask

  initial begin
    row_t fr;
    rob_types_pkg::rob_id_t first_id;
    rob_types_pkg::rob_id_t id;
    rob_types_pkg::rob_id_t held;
    rob_regs_pkg::reg_data_t d;
    exp_t e;
    int waited;
    void'($urandom(94));
    test_name = "reset";
    retired = 0;
    tvec_val = '0;
    rst = 1'b1;
    valid = 1'b0;
    error = 1'b0;
    ecause = rob_types_pkg::ECAUSE_ILLEGAL;
    retop = rob_types_pkg::RETOP_ALU;
    branch_inv = 1'b0;
    pc = '0;
    rd = '0;
    rd_en = 1'b0;
    bptag = '0;
    bptaken = 1'b0;
    target = '0;
    lsq_write = 1'b0;
    lsq_robid = '0;
    lsq_id = '0;
    ex_valid = 1'b0;
    ex_error = 1'b0;
    ex_ecause = rob_types_pkg::ECAUSE_ILLEGAL;
    ex_robid = '0;
    ex_result = '0;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    wb_adr = rob_regs_pkg::REG_TVEC;
    wb_dat_w = '0;
    repeat (4) @(posedge clk);
    #2;
    rst = 1'b0;
    check_ret(1'b0, '0, '0);
    check_branch(1'b0, '0, 1'b0);
    check_store(1'b0, '0);
    check_flush(1'b0, '0);
    check_full(1'b0);
    check_id('0, robid);
    if (wb_ack !== 1'b0) mismatch("wb_ack", 32'd0, 32'(wb_ack));
    check_reg(rob_regs_pkg::REG_TVEC, '0);
    check_reg(rob_regs_pkg::REG_RETCNT, '0);

    run_group("in order retire", 0, 7);
    run_group("mispredict flush", 7, 4);
    run_group("jump flush", 11, 2);

    // trap vector keeps only word-aligned bits
    test_name = "exception";
    wb_access(1'b1, rob_regs_pkg::REG_TVEC, 32'h1000_0103, d);
    tvec_val = 32'h1000_0103 & ~32'h3;
    check_reg(rob_regs_pkg::REG_TVEC, tvec_val);
    run_group("exception", 13, 3);
    check_reg(rob_regs_pkg::REG_EPC, pc_of(14));
    check_reg(rob_regs_pkg::REG_CAUSE, {27'd0, rob_types_pkg::ECAUSE_LOAD_FAULT});

    // any write data clears the count
    test_name = "retire count";
    check_reg(rob_regs_pkg::REG_RETCNT, 32'(retired));
    wb_access(1'b1, rob_regs_pkg::REG_RETCNT, 32'h0000_00a5, d);
    check_reg(rob_regs_pkg::REG_RETCNT, '0);

    // fill every slot and execute only the oldest
    test_name = "full stall";
    fr = rows[0];
    fr.rd = 5'd31;
    fr.result = 32'hf00d;
    fr.gap = 3'd0;
    e = '0;
    e.wr = 1'b1;
    e.rd = 5'd31;
    e.result = 32'hf00d;
    exp_q.push_back(e);
    for (int i = 0; i < `ROB_DEPTH; i++) begin
      decode_row(fr, i, id);
      if (i == 0) first_id = id;
      fr.rd_en = 1'b0;
    end
    check_full(1'b1);
    held = robid;
    valid = 1'b1;
    repeat (3) tick();
    check_full(1'b1);
    check_id(held, robid);
    write_back(fr, first_id);
    waited = 0;
    while (full) begin
      if (waited == 20) give_up("full never dropped after the head retired");
      tick();
      waited++;
    end
    if (exp_q.size() != 0) give_up("decode was accepted before the head entry retired");
    tick();
    check_id(held + 1'b1, robid);
    valid = 1'b0;

    $display("TB PASSED");
    $finish;
  end

endmodule

// File: all.f
+incdir+include
logic/rob_types_pkg.sv
logic/rob_regs_pkg.sv
logic/retire_if.sv
logic/reorder_buffer.sv
logic/retire_regs.sv
logic/retire_top.sv
testbench/retire_tb.sv

// File: Makefile
# Verilator build and run of the retirement stage testbench

VERILATOR ?= verilator
TOP       ?= retire_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "TB PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
